//--- lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // ------------------------------
  // Memory geometry
  // ------------------------------
  localparam int MEM_WORDS      = 256;
  localparam int MEM_INDEX_BITS = 8;  // Word index taken from address bits 9:2

  // ------------------------------
  // Core-side types
  // ------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  byte_off_t;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } access_size_e;

  typedef struct packed {
    logic         is_store;
    access_size_e size;
    logic         sign_ext;  // Only meaningful for byte and halfword loads
    addr_t        addr;
    data_t        wdata;     // Store data, right-aligned as the core holds it
  } lsu_req_t;

  typedef struct packed {
    data_t rdata;
    logic  error;
  } lsu_rsp_t;

endpackage

`default_nettype wire

//--- axi_pkg.sv
`default_nettype none

package axi_pkg;

  // ------------------------------
  // Response codes
  // ------------------------------
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // ------------------------------
  // AXI-lite channel payloads
  // ------------------------------
  typedef struct packed {
    lsu_pkg::addr_t addr;
  } axi_ar_t;

  typedef struct packed {
    lsu_pkg::addr_t addr;
  } axi_aw_t;

  typedef struct packed {
    lsu_pkg::data_t data;
    lsu_pkg::strb_t strb;  // One bit per byte lane of data
  } axi_w_t;

  typedef struct packed {
    lsu_pkg::data_t data;
    resp_t          resp;
  } axi_r_t;

  typedef struct packed {
    resp_t resp;
  } axi_b_t;

endpackage

`default_nettype wire

//--- lsu_lane_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_lane_align (
  input  lsu_pkg::access_size_e size,
  input  logic                  sign_ext,
  input  lsu_pkg::byte_off_t    byte_off,
  input  lsu_pkg::data_t        store_data,
  input  lsu_pkg::data_t        bus_rdata,
  output lsu_pkg::data_t        lane_wdata,
  output lsu_pkg::strb_t        lane_strb,
  output lsu_pkg::data_t        load_data
);
  import lsu_pkg::*;

  logic [4:0] shift_bits;
  strb_t      base_strb;
  data_t      shifted_rdata;

  assign shift_bits = {byte_off, 3'b000};  // Byte offset as a bit count

  // ------------------------------
  // Store path
  // ------------------------------
  assign lane_wdata = store_data << shift_bits;

  always_comb begin
    case (size)
      SIZE_BYTE: base_strb = 4'b0001;
      SIZE_HALF: base_strb = 4'b0011;
      default:   base_strb = 4'b1111;
    endcase
  end

  assign lane_strb = base_strb << byte_off;

  // ------------------------------
  // Load path
  // ------------------------------
  assign shifted_rdata = bus_rdata >> shift_bits;

  always_comb begin
    case (size)
      SIZE_BYTE: load_data = {{24{sign_ext & shifted_rdata[7]}}, shifted_rdata[7:0]};
      SIZE_HALF: load_data = {{16{sign_ext & shifted_rdata[15]}}, shifted_rdata[15:0]};
      default:   load_data = bus_rdata;
    endcase
  end

endmodule

`default_nettype wire

//--- lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu (
  input  logic              clock,
  input  logic              reset,
  input  logic              req_valid,
  input  lsu_pkg::lsu_req_t req,
  output logic              rsp_valid,
  output lsu_pkg::lsu_rsp_t rsp,
  output logic              ar_valid,
  output axi_pkg::axi_ar_t  ar,
  input  logic              ar_ready,
  input  logic              r_valid,
  input  axi_pkg::axi_r_t   r,
  output logic              r_ready,
  output logic              aw_valid,
  output axi_pkg::axi_aw_t  aw,
  input  logic              aw_ready,
  output logic              w_valid,
  output axi_pkg::axi_w_t   w,
  input  logic              w_ready,
  input  logic              b_valid,
  input  axi_pkg::axi_b_t   b,
  output logic              b_ready
);
  import lsu_pkg::*;
  import axi_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    READ_ADDR,
    READ_DATA,
    WRITE_ADDR,
    WRITE_DATA,
    WRITE_RESP,
    DONE
  } state_e;

  state_e   state;
  lsu_req_t req_q;
  data_t    load_data;

  lsu_lane_align u_align (
    .size       (req_q.size),
    .sign_ext   (req_q.sign_ext),
    .byte_off   (req_q.addr[1:0]),
    .store_data (req_q.wdata),
    .bus_rdata  (r.data),
    .lane_wdata (w.data),
    .lane_strb  (w.strb),
    .load_data  (load_data)
  );

  assign ar.addr = req_q.addr;
  assign aw.addr = req_q.addr;

  // ------------------------------
  // Handshake sequencing
  // ------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= IDLE;
      ar_valid  <= 1'b0;
      r_ready   <= 1'b0;
      aw_valid  <= 1'b0;
      w_valid   <= 1'b0;
      b_ready   <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (req_valid && req.is_store) begin
            aw_valid <= 1'b1;
            state    <= WRITE_ADDR;
          end else if (req_valid) begin
            ar_valid <= 1'b1;
            state    <= READ_ADDR;
          end
        end
        READ_ADDR: begin
          if (ar_ready) begin
            ar_valid <= 1'b0;
            r_ready  <= 1'b1;
            state    <= READ_DATA;
          end
        end
        READ_DATA: begin
          if (r_valid) begin
            r_ready   <= 1'b0;
            rsp_valid <= 1'b1;
            state     <= DONE;
          end
        end
        WRITE_ADDR: begin
          if (aw_ready) begin
            aw_valid <= 1'b0;
            w_valid  <= 1'b1;
            state    <= WRITE_DATA;
          end
        end
        WRITE_DATA: begin
          if (w_ready) begin
            w_valid <= 1'b0;
            b_ready <= 1'b1;
            state   <= WRITE_RESP;
          end
        end
        WRITE_RESP: begin
          if (b_valid) begin
            b_ready   <= 1'b0;
            rsp_valid <= 1'b1;
            state     <= DONE;
          end
        end
        default: begin
          rsp_valid <= 1'b0;  // Response strobe lasts this one cycle
          state     <= IDLE;
        end
      endcase
    end
  end

  // ------------------------------
  // Request and response payload
  // ------------------------------
  always_ff @(posedge clock) begin
    if (state == IDLE && req_valid) begin
      req_q <= req;
    end
    if (r_valid && r_ready) begin
      rsp.rdata <= (r.resp == RESP_OKAY) ? load_data : '0;
      rsp.error <= (r.resp != RESP_OKAY);
    end else if (b_valid && b_ready) begin
      rsp.rdata <= '0;
      rsp.error <= (b.resp != RESP_OKAY);
    end
  end

endmodule

`default_nettype wire

//--- axi_sram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_sram (
  input  logic             clock,
  input  logic             reset,
  input  logic             ar_valid,
  input  axi_pkg::axi_ar_t ar,
  output logic             ar_ready,
  output logic             r_valid,
  output axi_pkg::axi_r_t  r,
  input  logic             r_ready,
  input  logic             aw_valid,
  input  axi_pkg::axi_aw_t aw,
  output logic             aw_ready,
  input  logic             w_valid,
  input  axi_pkg::axi_w_t  w,
  output logic             w_ready,
  output logic             b_valid,
  output axi_pkg::axi_b_t  b,
  input  logic             b_ready
);
  import lsu_pkg::*;
  import axi_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    READ_RESP,
    WRITE_DATA,
    WRITE_RESP
  } state_e;

  typedef logic [MEM_INDEX_BITS-1:0] index_t;

  state_e state;
  data_t  mem [MEM_WORDS];
  addr_t  aw_addr_q;
  logic   ar_in_range;
  logic   aw_in_range;
  index_t ar_index;
  index_t aw_index;

  assign ar_in_range = (ar.addr[31:MEM_INDEX_BITS+2] == '0);
  assign aw_in_range = (aw_addr_q[31:MEM_INDEX_BITS+2] == '0);
  assign ar_index    = ar.addr[MEM_INDEX_BITS+1:2];
  assign aw_index    = aw_addr_q[MEM_INDEX_BITS+1:2];

  // Address readies follow valid while idle, reads win a tie
  assign ar_ready = (state == IDLE) && ar_valid;
  assign aw_ready = (state == IDLE) && aw_valid && !ar_valid;
  assign r_valid  = (state == READ_RESP);
  assign w_ready  = (state == WRITE_DATA);
  assign b_valid  = (state == WRITE_RESP);

  // ------------------------------
  // Slave FSM
  // ------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (ar_valid) begin
            state <= READ_RESP;
          end else if (aw_valid) begin
            state <= WRITE_DATA;
          end
        end
        READ_RESP:  if (r_ready) state <= IDLE;
        WRITE_DATA: if (w_valid) state <= WRITE_RESP;
        default:    if (b_ready) state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (ar_valid && ar_ready) begin
      r.data <= ar_in_range ? mem[ar_index] : '0;
      r.resp <= ar_in_range ? RESP_OKAY : RESP_SLVERR;
    end
    if (aw_valid && aw_ready) begin
      aw_addr_q <= aw.addr;
    end
    if (w_valid && w_ready) begin
      b.resp <= aw_in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // Only the strobed lanes of an in-range word change
  always_ff @(posedge clock) begin
    if (w_valid && w_ready && aw_in_range) begin
      for (int i = 0; i < 4; i++) begin
        if (w.strb[i]) begin
          mem[aw_index][8*i +: 8] <= w.data[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- lsu_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_top (
  input  logic              clock,
  input  logic              reset,
  input  logic              req_valid,
  input  lsu_pkg::lsu_req_t req,
  output logic              rsp_valid,
  output lsu_pkg::lsu_rsp_t rsp
);
  import axi_pkg::*;

  // ------------------------------
  // AXI-lite channel wires
  // ------------------------------
  logic    ar_valid;
  logic    ar_ready;
  axi_ar_t ar;
  logic    r_valid;
  logic    r_ready;
  axi_r_t  r;
  logic    aw_valid;
  logic    aw_ready;
  axi_aw_t aw;
  logic    w_valid;
  logic    w_ready;
  axi_w_t  w;
  logic    b_valid;
  logic    b_ready;
  axi_b_t  b;

  lsu u_lsu (
    .clock     (clock),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .ar_valid  (ar_valid),
    .ar        (ar),
    .ar_ready  (ar_ready),
    .r_valid   (r_valid),
    .r         (r),
    .r_ready   (r_ready),
    .aw_valid  (aw_valid),
    .aw        (aw),
    .aw_ready  (aw_ready),
    .w_valid   (w_valid),
    .w         (w),
    .w_ready   (w_ready),
    .b_valid   (b_valid),
    .b         (b),
    .b_ready   (b_ready)
  );

  axi_sram u_sram (
    .clock    (clock),
    .reset    (reset),
    .ar_valid (ar_valid),
    .ar       (ar),
    .ar_ready (ar_ready),
    .r_valid  (r_valid),
    .r        (r),
    .r_ready  (r_ready),
    .aw_valid (aw_valid),
    .aw       (aw),
    .aw_ready (aw_ready),
    .w_valid  (w_valid),
    .w        (w),
    .w_ready  (w_ready),
    .b_valid  (b_valid),
    .b        (b),
    .b_ready  (b_ready)
  );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clock
);
  localparam int HALF_PERIOD_NS = 20;  // 40 ns period

  initial clock = 1'b0;

  always #HALF_PERIOD_NS clock = ~clock;

endmodule

`default_nettype wire

//--- lsu_mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_checker (
  input logic             clock,
  input logic             reset,
  input logic             rsp_valid,
  input logic             ar_valid,
  input logic             ar_ready,
  input axi_pkg::axi_ar_t ar,
  input logic             r_valid,
  input logic             r_ready,
  input axi_pkg::axi_r_t  r,
  input logic             aw_valid,
  input logic             aw_ready,
  input axi_pkg::axi_aw_t aw,
  input logic             w_valid,
  input logic             w_ready,
  input axi_pkg::axi_w_t  w,
  input logic             b_valid,
  input logic             b_ready,
  input axi_pkg::axi_b_t  b
);

  // ------------------------------
  // Valid holds with its payload until ready
  // ------------------------------
  ar_hold: assert property (@(posedge clock) disable iff (reset)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar))
    else $error("ar_valid or address changed before ar_ready");
  r_hold: assert property (@(posedge clock) disable iff (reset)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else $error("r_valid or read data changed before r_ready");
  aw_hold: assert property (@(posedge clock) disable iff (reset)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw))
    else $error("aw_valid or address changed before aw_ready");
  w_hold: assert property (@(posedge clock) disable iff (reset)
    w_valid && !w_ready |=> w_valid && $stable(w))
    else $error("w_valid or write data changed before w_ready");
  b_hold: assert property (@(posedge clock) disable iff (reset)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else $error("b_valid or write response changed before b_ready");

  rsp_single: assert property (@(posedge clock) disable iff (reset)
    rsp_valid |=> !rsp_valid)
    else $error("rsp_valid stayed high for two cycles in a row");

  // Only one address channel is active at a time
  addr_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(ar_valid && aw_valid))
    else $error("ar_valid and aw_valid are high together");

endmodule

bind lsu lsu_mem_checker u_checker (
  .clock     (clock),
  .reset     (reset),
  .rsp_valid (rsp_valid),
  .ar_valid  (ar_valid),
  .ar_ready  (ar_ready),
  .ar        (ar),
  .r_valid   (r_valid),
  .r_ready   (r_ready),
  .r         (r),
  .aw_valid  (aw_valid),
  .aw_ready  (aw_ready),
  .aw        (aw),
  .w_valid   (w_valid),
  .w_ready   (w_ready),
  .w         (w),
  .b_valid   (b_valid),
  .b_ready   (b_ready),
  .b         (b)
);

`default_nettype wire

//--- lsu_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_tb;
  import lsu_pkg::*;

  localparam int NUM_OPS        = 583;  // Fill, directed tests and the random run
  localparam int TIMEOUT_CYCLES = 16 + NUM_OPS * 20;

  logic     clock;
  logic     reset;
  logic     req_valid;
  lsu_req_t req;
  logic     rsp_valid;
  lsu_rsp_t rsp;

  data_t       model_mem [MEM_WORDS];
  logic [32:0] exp_q [$];  // {error, rdata} of each outstanding request
  string       test_name;
  int          req_count;
  int          rsp_count;
  int          test_errors;
  int          error_count;
  int          tests_run;
  int          tests_failed;

  tb_clock_gen clock_gen (
    .clock (clock)
  );

  lsu_mem_top dut (
    .clock     (clock),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic logic in_range(input addr_t addr);
    return addr < addr_t'(MEM_WORDS * 4);
  endfunction

  function automatic int size_bytes(input access_size_e size);
    case (size)
      SIZE_BYTE: return 1;
      SIZE_HALF: return 2;
      default:   return 4;
    endcase
  endfunction

  function automatic data_t fill_value(input addr_t addr);
    return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic logic [32:0] expected_load(input data_t word, input access_size_e size,
                                                input logic sign_ext, input byte_off_t off,
                                                input logic ok);
    data_t value;
    int    nbytes;
    value  = '0;
    nbytes = size_bytes(size);
    if (!ok) begin
      return {1'b1, 32'h0};  // Out of range reads as zero with an error
    end
    for (int i = 0; i < nbytes; i++) begin
      value[8*i +: 8] = word[8*(off + i) +: 8];
    end
    if (sign_ext && nbytes < 4 && value[8*nbytes-1]) begin
      for (int i = 8 * nbytes; i < 32; i++) begin
        value[i] = 1'b1;
      end
    end
    return {1'b0, value};
  endfunction

  task automatic write_model(input addr_t addr, input access_size_e size, input data_t wdata);
    int nbytes;
    nbytes = size_bytes(size);
    if (in_range(addr)) begin
      for (int i = 0; i < nbytes; i++) begin
        model_mem[addr[MEM_INDEX_BITS+1:2]][8*(addr[1:0] + i) +: 8] = wdata[8*i +: 8];
      end
    end
  endtask

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  task automatic issue_access(input logic is_store, input access_size_e size,
                              input logic sign_ext, input addr_t addr, input data_t wdata);
    if (is_store) begin
      exp_q.push_back({!in_range(addr), 32'h0});
      write_model(addr, size, wdata);
    end else begin
      exp_q.push_back(expected_load(model_mem[addr[MEM_INDEX_BITS+1:2]], size, sign_ext,
                                    addr[1:0], in_range(addr)));
    end
    req_count++;
    @(posedge clock);
    #1;
    req_valid    = 1'b1;
    req.is_store = is_store;
    req.size     = size;
    req.sign_ext = sign_ext;
    req.addr     = addr;
    req.wdata    = wdata;
    @(posedge clock);
    #1;
    req_valid = 1'b0;
    wait (rsp_count == req_count);
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("%s: pass", test_name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", test_name, test_errors);
    end
  endtask

  task automatic record_error();
    test_errors++;
    error_count++;
  endtask

  // ------------------------------
  // Response comparison
  // ------------------------------
  always begin : compare
    logic [32:0] expected;
    @(posedge clock);
    #1;
    if (rsp_valid) begin
      if (exp_q.size() == 0) begin
        $display("A response arrived in %s with no request outstanding", test_name);
        record_error();
      end else begin
        expected = exp_q.pop_front();
        if (rsp.error !== expected[32]) begin
          $display("Fail %s error flag expected %0b actual %0b", test_name, expected[32],
                   rsp.error);
          record_error();
        end
        if (rsp.rdata !== expected[31:0]) begin
          $display("Fail %s rdata expected %h actual %h", test_name, expected[31:0],
                   rsp.rdata);
          record_error();
        end
      end
      rsp_count++;
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clock);
    $display("Timeout after %0d cycles, the DUT stopped answering requests", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [31:0]  bits;
    addr_t        addr;
    access_size_e size;
    void'($urandom(15));
    reset     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b0;

    begin_test("fill");
    for (int i = 0; i < MEM_WORDS; i++) begin
      issue_access(1'b1, SIZE_WORD, 1'b0, addr_t'(i * 4), fill_value(addr_t'(i * 4)));
    end
    end_test();

    begin_test("word store and load");
    issue_access(1'b1, SIZE_WORD, 1'b0, 32'h100, 32'hC0DE_1357);
    issue_access(1'b0, SIZE_WORD, 1'b0, 32'h100, '0);
    end_test();

    begin_test("byte lane merge");
    for (int lane = 0; lane < 4; lane++) begin
      issue_access(1'b1, SIZE_BYTE, 1'b0, addr_t'(32'h40 + lane),
                   data_t'(32'h7777_77A0 + lane * 17));
      issue_access(1'b0, SIZE_WORD, 1'b0, 32'h40, '0);
    end
    end_test();

    begin_test("sign and zero extension");
    issue_access(1'b1, SIZE_WORD, 1'b0, 32'h80, 32'h8090_A0F0);  // Top bit set in every byte
    for (int off = 0; off < 4; off++) begin
      for (int ext = 0; ext < 2; ext++) begin
        issue_access(1'b0, SIZE_BYTE, ext[0], addr_t'(32'h80 + off), '0);
        if (off % 2 == 0) begin
          issue_access(1'b0, SIZE_HALF, ext[0], addr_t'(32'h80 + off), '0);
        end
      end
    end
    end_test();

    begin_test("out of range");
    issue_access(1'b0, SIZE_WORD, 1'b0, 32'h410, '0);
    issue_access(1'b1, SIZE_WORD, 1'b0, 32'h410, 32'h0BAD_F00D);  // Would alias word 0x10
    issue_access(1'b1, SIZE_BYTE, 1'b0, 32'h8000_0013, 32'hFF);
    issue_access(1'b0, SIZE_WORD, 1'b0, 32'h10, '0);
    end_test();

    begin_test("random accesses");
    for (int n = 0; n < 300; n++) begin
      bits = $urandom();
      addr = $urandom();
      addr = (bits[7:4] == 4'd0) ? (addr | 32'h400) : (addr & 32'h3FF);
      size = (bits[9:8] == 2'd0) ? SIZE_BYTE : (bits[9:8] == 2'd1) ? SIZE_HALF : SIZE_WORD;
      if (size == SIZE_HALF) begin
        addr[0] = 1'b0;
      end
      if (size == SIZE_WORD) begin
        addr[1:0] = 2'b00;
      end
      issue_access(bits[0], size, bits[1], addr, $urandom());
    end
    end_test();

    repeat (4) @(posedge clock);
    if (exp_q.size() != 0 || rsp_count != req_count) begin
      $display("Got %0d responses for %0d requests", rsp_count, req_count);
      error_count++;
    end
    $display("Tests %0d, failed %0d, requests %0d, responses %0d, errors %0d",
             tests_run, tests_failed, req_count, rsp_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
lsu_pkg.sv
axi_pkg.sv
lsu_lane_align.sv
lsu.sv
axi_sram.sv
lsu_mem_top.sv
tb_clock_gen.sv
lsu_mem_checker.sv
lsu_mem_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module lsu_mem_tb -o sim_lsu_mem \
  && ./obj_dir/sim_lsu_mem | tee /dev/stderr | grep -q "TEST OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
